// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := pkbus_mem_tb
FILELIST  := pkbus_mem_subsystem.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== pkbus_mem_subsystem.f ====
source/pkbus_pkg.sv
source/pkbus_mem_slave.sv
source/pkbus_decoder.sv
source/pkbus_mem_subsystem.sv
verification/pkbus_mem_assert.sv
verification/pkbus_mem_tb.sv

// ==== source/pkbus_decoder.sv ====
// Address decoder steering one PKBus master to two slaves and muxing their responses back
module pkbus_decoder #(
    parameter pkbus_pkg::bus_addr_t SPLIT_ADDR = 32'h0000_0400
) (
    input  logic                 clk_i,
    input  logic                 nrst_i,
    input  logic                 req_i,
    input  pkbus_pkg::bus_addr_t addr_i,
    input  logic                 s0_ack_i,
    input  logic                 s0_seqslv_i,
    input  pkbus_pkg::bus_data_t s0_rdata_i,
    input  logic                 s0_bad_read_i,
    input  logic                 s1_ack_i,
    input  logic                 s1_seqslv_i,
    input  pkbus_pkg::bus_data_t s1_rdata_i,
    input  logic                 s1_bad_read_i,
    output logic                 s0_req_o,
    output logic                 s1_req_o,
    output logic                 ack_o,
    output logic                 seqslv_o,
    output pkbus_pkg::bus_data_t rdata_o,
    output logic                 bad_read_o
);

    logic req_q;    // Request seen last cycle
    logic sel_q;    // Held selection, 1 means slave 1
    logic req_rise;
    logic addr_hi;
    logic sel;

    assign req_rise = req_i && !req_q;
    assign addr_hi  = addr_i >= SPLIT_ADDR;
    assign sel      = req_rise ? addr_hi : sel_q; // New decode only on a fresh request

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            req_q <= 1'b0;
            sel_q <= 1'b0;
        end else begin
            req_q <= req_i;
            if (req_rise) begin
                sel_q <= addr_hi; // Kept so read data stays routed after req drops
            end
        end
    end

    assign s0_req_o = req_i && !sel;
    assign s1_req_o = req_i && sel;

    assign ack_o      = sel ? s1_ack_i : s0_ack_i;
    assign seqslv_o   = sel ? s1_seqslv_i : s0_seqslv_i;
    assign rdata_o    = sel ? s1_rdata_i : s0_rdata_i;
    assign bad_read_o = s0_bad_read_i || s1_bad_read_i; // Either slave's sticky flag

endmodule

// ==== source/pkbus_mem_slave.sv ====
// Byte-array memory slave on PKBus serving byte, word, tword and stream transfers at SLAVE_BASE
module pkbus_mem_slave #(
    parameter pkbus_pkg::bus_addr_t SLAVE_BASE = '0,
    parameter int unsigned          SLAVE_SIZE = 1024
) (
    input  logic                 clk_i,
    input  logic                 nrst_i,
    input  logic                 req_i,
    input  pkbus_pkg::bus_rw_e   rw_i,
    input  pkbus_pkg::bus_size_e size_i,
    input  pkbus_pkg::bus_addr_t addr_i,
    input  pkbus_pkg::bus_data_t wdata_i,
    output logic                 ack_o,
    output logic                 seqslv_o,
    output pkbus_pkg::bus_data_t rdata_o,
    output logic                 bad_read_o
);
    import pkbus_pkg::*;

    localparam int IDX_W  = $clog2(SLAVE_SIZE);
    localparam int BEAT_W = $clog2(TWORD_BEATS);
    localparam int EXT_W  = BUS_ADDR_W + 1; // Room for the carry of the range check

    typedef enum logic [2:0] {
        ST_READY,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE_ARB,
        ST_WRITE_PREP,
        ST_WRITE,
        ST_WRITE_WAIT,
        ST_DONE
    } state_e;

    state_e            state;
    logic [BEAT_W-1:0] beat_cnt;   // Tword position, stays zero otherwise
    bus_addr_t         rel_addr;
    logic [EXT_W-1:0]  beat_addr;  // First byte of the current beat
    logic [EXT_W-1:0]  last_byte;  // Last byte touched by the current beat
    logic              in_range;
    logic              multi_beat;
    logic [IDX_W-1:0]  base_idx;
    bus_data_t         mem_word;

    logic [7:0] mem [SLAVE_SIZE];

    assign rel_addr   = addr_i - SLAVE_BASE; // Addresses below base wrap far out of range
    assign beat_addr  = {1'b0, rel_addr} + EXT_W'({beat_cnt, 2'b00});
    assign last_byte  = beat_addr + ((size_i == BUS_SIZE_BYTE) ? EXT_W'(0) : EXT_W'(3));
    assign in_range   = last_byte < EXT_W'(SLAVE_SIZE);
    assign multi_beat = (size_i == BUS_SIZE_TWORD) || (size_i == BUS_SIZE_STREAM);
    assign base_idx   = beat_addr[IDX_W-1:0];

    // Little-endian word at the current beat
    assign mem_word = {
        mem[base_idx + IDX_W'(3)],
        mem[base_idx + IDX_W'(2)],
        mem[base_idx + IDX_W'(1)],
        mem[base_idx]
    };

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            for (int i = 0; i < SLAVE_SIZE; i++) begin
                mem[i] <= '0;
            end
            state      <= ST_READY;
            beat_cnt   <= '0;
            ack_o      <= 1'b0;
            seqslv_o   <= 1'b0;
            rdata_o    <= '0;
            bad_read_o <= 1'b0;
        end else begin
            case (state)
                ST_READY: begin
                    if (req_i) begin
                        ack_o    <= 1'b1; // Request taken
                        beat_cnt <= '0;
                        state    <= (rw_i == BUS_READ) ? ST_READ : ST_WRITE_ARB;
                    end
                end
                ST_READ: begin
                    if (!in_range) begin
                        rdata_o    <= '0;
                        bad_read_o <= 1'b1; // Sticky until reset
                    end else if (size_i == BUS_SIZE_BYTE) begin
                        rdata_o <= {{(BUS_DATA_W-8){1'b0}}, mem[base_idx]};
                    end else begin
                        rdata_o <= mem_word;
                    end
                    if (multi_beat) begin
                        seqslv_o <= 1'b1; // Beat data valid next cycle
                        state    <= ST_READ_WAIT;
                    end else begin
                        state <= ST_DONE;
                    end
                end
                ST_READ_WAIT: begin
                    seqslv_o <= 1'b0;
                    if (size_i == BUS_SIZE_TWORD) begin
                        if (beat_cnt == BEAT_W'(TWORD_BEATS - 1)) begin
                            state <= ST_DONE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            state    <= ST_READ;
                        end
                    end else if (!req_i) begin
                        state <= ST_DONE; // Master ended the stream
                    end else begin
                        state <= ST_READ;
                    end
                end
                ST_WRITE_ARB: begin
                    state <= multi_beat ? ST_WRITE_PREP : ST_WRITE;
                end
                ST_WRITE_PREP: begin
                    seqslv_o <= 1'b1; // Master puts the first word up
                    state    <= ST_WRITE;
                end
                ST_WRITE: begin
                    // Writes past the array are dropped
                    if (in_range) begin
                        if (size_i == BUS_SIZE_BYTE) begin
                            mem[base_idx] <= wdata_i[7:0];
                        end else begin
                            mem[base_idx]             <= wdata_i[7:0];
                            mem[base_idx + IDX_W'(1)] <= wdata_i[15:8];
                            mem[base_idx + IDX_W'(2)] <= wdata_i[23:16];
                            mem[base_idx + IDX_W'(3)] <= wdata_i[31:24];
                        end
                    end
                    seqslv_o <= 1'b0; // Word stored
                    state    <= multi_beat ? ST_WRITE_WAIT : ST_DONE;
                end
                ST_WRITE_WAIT: begin
                    if (size_i == BUS_SIZE_TWORD) begin
                        if (beat_cnt == BEAT_W'(TWORD_BEATS - 1)) begin
                            state <= ST_DONE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            seqslv_o <= 1'b1;
                            state    <= ST_WRITE;
                        end
                    end else if (!req_i) begin
                        state <= ST_DONE;
                    end else begin
                        seqslv_o <= 1'b1; // Next stream word
                        state    <= ST_WRITE;
                    end
                end
                ST_DONE: begin
                    ack_o <= 1'b0; // Transfer finished
                    if (!req_i) begin
                        state <= ST_READY;
                    end
                end
                default: begin
                    state <= ST_READY;
                end
            endcase
        end
    end

endmodule

// ==== source/pkbus_mem_subsystem.sv ====
// PKBus memory subsystem top; one master port decoded onto two memory slaves at MEM0_BASE and MEM1_BASE
module pkbus_mem_subsystem #(
    parameter pkbus_pkg::bus_addr_t MEM0_BASE = 32'h0000_0000,
    parameter pkbus_pkg::bus_addr_t MEM1_BASE = 32'h0000_0400,
    parameter int unsigned          MEM_SIZE  = 256
) (
    input  logic                 clk_i,
    input  logic                 nrst_i,
    input  logic                 req_i,
    input  pkbus_pkg::bus_rw_e   rw_i,
    input  pkbus_pkg::bus_size_e size_i,
    input  pkbus_pkg::bus_addr_t addr_i,
    input  pkbus_pkg::bus_data_t wdata_i,
    output logic                 ack_o,
    output logic                 seqslv_o,
    output pkbus_pkg::bus_data_t rdata_o,
    output logic                 bad_read_o
);
    import pkbus_pkg::*;

    logic      s0_req, s0_ack, s0_seqslv, s0_bad_read;
    logic      s1_req, s1_ack, s1_seqslv, s1_bad_read;
    bus_data_t s0_rdata;
    bus_data_t s1_rdata;

    pkbus_decoder #(
        .SPLIT_ADDR (MEM1_BASE) // Everything from slave 1's base upward
    ) u_decoder (
        .clk_i         (clk_i),
        .nrst_i        (nrst_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .s0_ack_i      (s0_ack),
        .s0_seqslv_i   (s0_seqslv),
        .s0_rdata_i    (s0_rdata),
        .s0_bad_read_i (s0_bad_read),
        .s1_ack_i      (s1_ack),
        .s1_seqslv_i   (s1_seqslv),
        .s1_rdata_i    (s1_rdata),
        .s1_bad_read_i (s1_bad_read),
        .s0_req_o      (s0_req),
        .s1_req_o      (s1_req),
        .ack_o         (ack_o),
        .seqslv_o      (seqslv_o),
        .rdata_o       (rdata_o),
        .bad_read_o    (bad_read_o)
    );

    pkbus_mem_slave #(
        .SLAVE_BASE (MEM0_BASE),
        .SLAVE_SIZE (MEM_SIZE)
    ) u_mem0 (
        .clk_i      (clk_i),
        .nrst_i     (nrst_i),
        .req_i      (s0_req),
        .rw_i       (rw_i),
        .size_i     (size_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .ack_o      (s0_ack),
        .seqslv_o   (s0_seqslv),
        .rdata_o    (s0_rdata),
        .bad_read_o (s0_bad_read)
    );

    pkbus_mem_slave #(
        .SLAVE_BASE (MEM1_BASE),
        .SLAVE_SIZE (MEM_SIZE)
    ) u_mem1 (
        .clk_i      (clk_i),
        .nrst_i     (nrst_i),
        .req_i      (s1_req),
        .rw_i       (rw_i),
        .size_i     (size_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .ack_o      (s1_ack),
        .seqslv_o   (s1_seqslv),
        .rdata_o    (s1_rdata),
        .bad_read_o (s1_bad_read)
    );

endmodule

// ==== source/pkbus_pkg.sv ====
// Shared PKBus widths, transfer-size and direction encodings; imported by the RTL and testbench
package pkbus_pkg;

    localparam int BUS_ADDR_W = 32; // Byte address
    localparam int BUS_DATA_W = 32; // One bus word

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // Transfer size requested by the master
    typedef enum logic [1:0] {
        BUS_SIZE_BYTE   = 2'd0, // Single byte, low lane
        BUS_SIZE_WORD   = 2'd1, // Four bytes, little-endian
        BUS_SIZE_TWORD  = 2'd2, // Three consecutive words
        BUS_SIZE_STREAM = 2'd3  // Repeated words at one address
    } bus_size_e;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_rw_e;

    // Words moved by one tword transfer, at addr, addr+4 and addr+8
    localparam int TWORD_BEATS = 3;

endpackage

// ==== verification/pkbus_mem_assert.sv ====
// Bus protocol checker bound into the memory subsystem top; watches ack, seqslv and reset behavior
module pkbus_mem_assert (
    input logic clk_i,
    input logic nrst_i,
    input logic req_i,
    input logic ack_i,
    input logic seqslv_i,
    input logic bad_read_i
);
    timeunit 1ns;
    timeprecision 100ps;

    seqslv_inside_ack: assert property (@(posedge clk_i) disable iff (!nrst_i)
        seqslv_i |-> ack_i)
        else $error("seqslv_o high outside an acknowledged transfer");

    // Ack only answers a request seen on the previous clock
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!nrst_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without req_i");

    bad_read_sticky: assert property (@(posedge clk_i) disable iff (!nrst_i)
        !$fell(bad_read_i))
        else $error("bad_read_o fell while out of reset");

    // Looks at the outputs after the first clock edge out of reset
    idle_after_reset: assert property (@(posedge clk_i)
        $rose(nrst_i) |=> (!ack_i && !seqslv_i))
        else $error("ack_o or seqslv_o high in the first cycle after reset");

endmodule

bind pkbus_mem_subsystem pkbus_mem_assert u_assert (
    .clk_i      (clk_i),
    .nrst_i     (nrst_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .seqslv_i   (seqslv_o),
    .bad_read_i (bad_read_o)
);

// ==== verification/pkbus_mem_tb.sv ====
// Self-checking testbench for the PKBus memory subsystem; run it as the simulation top
module pkbus_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pkbus_pkg::*;

    localparam bus_addr_t   MEM0_BASE = 32'h0000_0000;
    localparam bus_addr_t   MEM1_BASE = 32'h0000_0400;
    localparam int unsigned MEM_SIZE  = 256;
    localparam int          IDX_W     = $clog2(2 * MEM_SIZE);
    localparam int          TIMEOUT   = 64; // Cycles allowed per wait
    localparam int          N_RANDOM  = 60;
    localparam int          MAX_BEATS = 8;

    logic      clk_i;
    logic      nrst_i;
    logic      req_i;
    bus_rw_e   rw_i;
    bus_size_e size_i;
    bus_addr_t addr_i;
    bus_data_t wdata_i;
    logic      ack_o;
    logic      seqslv_o;
    bus_data_t rdata_o;
    logic      bad_read_o;

    logic [31:0] rng_state;
    logic [7:0]  model_mem [2 * MEM_SIZE]; // Slave 0 bytes, then slave 1
    logic        model_bad;                // Sticky like the DUT flag
    bus_data_t   beat_buf [MAX_BEATS];     // Words to write or words expected per beat
    int          err_cnt;
    int          check_cnt;
    int          timeout_cnt;

    pkbus_mem_subsystem #(
        .MEM0_BASE (MEM0_BASE),
        .MEM1_BASE (MEM1_BASE),
        .MEM_SIZE  (MEM_SIZE)
    ) u_pkbus_mem_subsystem (
        .clk_i      (clk_i),
        .nrst_i     (nrst_i),
        .req_i      (req_i),
        .rw_i       (rw_i),
        .size_i     (size_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .ack_o      (ack_o),
        .seqslv_o   (seqslv_o),
        .rdata_o    (rdata_o),
        .bad_read_o (bad_read_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return next_rand() % n;
    endfunction

    function automatic int unsigned size_bytes(input bus_size_e size);
        return (size == BUS_SIZE_BYTE) ? 1 : 4;
    endfunction

    function automatic bus_addr_t slave_addr(input int unsigned slave, input int unsigned off);
        return ((slave == 0) ? MEM0_BASE : MEM1_BASE) + bus_addr_t'(off);
    endfunction

    function automatic logic [IDX_W-1:0] model_idx(input int unsigned slave,
                                                   input int unsigned off);
        return IDX_W'(slave * MEM_SIZE + off);
    endfunction

    // Out-of-range reads give zero and raise the sticky flag
    function automatic bus_data_t model_read(input int unsigned slave, input int unsigned off,
                                             input bus_size_e size);
        bus_data_t   data;
        int unsigned nbytes;
        data   = '0;
        nbytes = size_bytes(size);
        if (off + nbytes > MEM_SIZE) begin
            model_bad = 1'b1;
        end else begin
            for (int b = 0; b < int'(nbytes); b++) begin
                data[8*b +: 8] = model_mem[model_idx(slave, off + b)]; // Little-endian lanes
            end
        end
        return data;
    endfunction

    function automatic void model_write(input int unsigned slave, input int unsigned off,
                                        input bus_size_e size, input bus_data_t data);
        int unsigned nbytes;
        nbytes = size_bytes(size);
        if (off + nbytes <= MEM_SIZE) begin // Whole access dropped otherwise
            for (int b = 0; b < int'(nbytes); b++) begin
                model_mem[model_idx(slave, off + b)] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_data(input string name, input bus_data_t expected,
                              input bus_data_t actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack_o !== level && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (ack_o !== level) begin
            timeout_cnt++;
            $display("Timeout: ack_o never reached level %0d at %0t", level, $time);
            finish_run();
        end
    endtask

    task automatic wait_seqslv(input logic level);
        int cycles;
        cycles = 0;
        while (seqslv_o !== level && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (seqslv_o !== level) begin
            timeout_cnt++;
            $display("Timeout: seqslv_o never reached level %0d at %0t", level, $time);
            finish_run();
        end
    endtask

    // Byte or word transfer; read data is valid once ack has fallen
    task automatic single_transfer(input bus_rw_e rw, input bus_size_e size,
                                   input bus_addr_t addr, input bus_data_t wdata,
                                   output bus_data_t rdata);
        @(negedge clk_i);
        req_i   = 1'b1;
        rw_i    = rw;
        size_i  = size;
        addr_i  = addr;
        wdata_i = wdata;
        wait_ack(1'b1);
        wait_ack(1'b0);
        rdata = rdata_o;
        req_i = 1'b0;
    endtask

    // Tword or stream transfer, one beat per seqslv pulse
    task automatic burst_transfer(input bus_rw_e rw, input bus_size_e size,
                                  input bus_addr_t addr, input int unsigned beats);
        @(negedge clk_i);
        req_i   = 1'b1;
        rw_i    = rw;
        size_i  = size;
        addr_i  = addr;
        wdata_i = '0;
        wait_ack(1'b1);
        for (int k = 0; k < int'(beats); k++) begin
            wait_seqslv(1'b1);
            if (rw == BUS_WRITE) begin
                wdata_i = beat_buf[k]; // Stored when seqslv falls
            end else begin
                check_data("rdata_o", beat_buf[k], rdata_o);
            end
            if (size == BUS_SIZE_STREAM && k == int'(beats) - 1) begin
                req_i = 1'b0; // Ends the stream after this beat
            end
            wait_seqslv(1'b0);
        end
        wait_ack(1'b0);
        req_i = 1'b0;
    endtask

    task automatic read_check(input int unsigned slave, input int unsigned off,
                              input bus_size_e size);
        bus_data_t expected;
        bus_data_t actual;
        expected = model_read(slave, off, size);
        single_transfer(BUS_READ, size, slave_addr(slave, off), '0, actual);
        check_data("rdata_o", expected, actual);
        check_flag("bad_read_o", model_bad, bad_read_o);
    endtask

    task automatic write_access(input int unsigned slave, input int unsigned off,
                                input bus_size_e size, input bus_data_t data);
        bus_data_t ignored;
        model_write(slave, off, size, data);
        single_transfer(BUS_WRITE, size, slave_addr(slave, off), data, ignored);
        check_flag("bad_read_o", model_bad, bad_read_o);
    endtask

    initial begin
        int unsigned slave;
        int unsigned off;
        int unsigned roff;
        int unsigned lim;
        int unsigned beats;
        bus_size_e   size;
        bus_size_e   rsize;
        logic [31:0] r;
        clk_i       = 1'b0;
        nrst_i      = 1'b0;
        req_i       = 1'b0;
        rw_i        = BUS_READ;
        size_i      = BUS_SIZE_WORD;
        addr_i      = '0;
        wdata_i     = '0;
        rng_state   = 32'h2cee730c;
        model_bad   = 1'b0;
        err_cnt     = 0;
        check_cnt   = 0;
        timeout_cnt = 0;
        for (int i = 0; i < 2 * int'(MEM_SIZE); i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (4) @(negedge clk_i);
        nrst_i = 1'b1;
        check_flag("ack_o", 1'b0, ack_o);
        check_flag("seqslv_o", 1'b0, seqslv_o);
        check_flag("bad_read_o", 1'b0, bad_read_o);
        for (int n = 0; n < 8; n++) begin
            read_check(n % 2, rand_below(MEM_SIZE - 3), BUS_SIZE_WORD); // Cleared memory
        end

        // Byte and word writes, each followed by an overlapping read
        for (int n = 0; n < N_RANDOM; n++) begin
            r     = next_rand();
            slave = r[0];
            size  = r[1] ? BUS_SIZE_WORD : BUS_SIZE_BYTE;
            rsize = r[2] ? BUS_SIZE_WORD : BUS_SIZE_BYTE;
            off   = rand_below(MEM_SIZE - size_bytes(size) + 1);
            write_access(slave, off, size, next_rand());
            roff = (r[3] && off >= 2) ? off - 2 : off;
            lim  = MEM_SIZE - size_bytes(rsize);
            if (roff > lim) begin
                roff = lim;
            end
            read_check(slave, roff, rsize);
        end

        for (int s = 0; s < 2; s++) begin
            slave = s;
            off   = rand_below(MEM_SIZE - 4 * TWORD_BEATS + 1);
            for (int k = 0; k < TWORD_BEATS; k++) begin
                beat_buf[k] = next_rand();
                model_write(slave, off + 4 * k, BUS_SIZE_WORD, beat_buf[k]);
            end
            burst_transfer(BUS_WRITE, BUS_SIZE_TWORD, slave_addr(slave, off), TWORD_BEATS);
            for (int k = 0; k < TWORD_BEATS; k++) begin
                beat_buf[k] = model_read(slave, off + 4 * k, BUS_SIZE_WORD);
            end
            burst_transfer(BUS_READ, BUS_SIZE_TWORD, slave_addr(slave, off), TWORD_BEATS);
            read_check(slave, off + 4, BUS_SIZE_WORD); // Middle word

            off   = rand_below(MEM_SIZE - 3);
            beats = 3 + rand_below(4);
            for (int k = 0; k < int'(beats); k++) begin
                beat_buf[k] = next_rand();
                model_write(slave, off, BUS_SIZE_WORD, beat_buf[k]); // Last one wins
            end
            burst_transfer(BUS_WRITE, BUS_SIZE_STREAM, slave_addr(slave, off), beats);
            read_check(slave, off, BUS_SIZE_WORD);
            for (int k = 0; k < int'(beats); k++) begin
                beat_buf[k] = model_read(slave, off, BUS_SIZE_WORD);
            end
            burst_transfer(BUS_READ, BUS_SIZE_STREAM, slave_addr(slave, off), beats);
        end

        // Accesses running past the end of each slave
        read_check(0, MEM_SIZE - 2, BUS_SIZE_WORD);
        read_check(1, MEM_SIZE, BUS_SIZE_BYTE);
        write_access(1, MEM_SIZE - 1, BUS_SIZE_WORD, next_rand());
        write_access(0, MEM_SIZE + 40, BUS_SIZE_BYTE, next_rand());
        read_check(1, MEM_SIZE - 4, BUS_SIZE_WORD);
        for (int n = 0; n < 16; n++) begin
            read_check(rand_below(2), rand_below(MEM_SIZE - 3), BUS_SIZE_WORD);
        end
        check_flag("bad_read_o", 1'b1, bad_read_o);
        finish_run();
    end

endmodule
